// ==== logic/gcm_defs.svh ====
`ifndef GCM_DEFS_SVH
`define GCM_DEFS_SVH

////////////////////
// block geometry.
////////////////////

// one GCM block, bit 127 is GCM bit 0.
`define GCM_BLOCK_W 128

// multiplier operand bits per cycle, 1/2/4/8/16.
`define GHASH_DIGIT 8

////////////////////
// session counters.
////////////////////

`define GCM_CNT_W 32   // aad and text block counts.

`endif

// ==== logic/gcm_pkg.sv ====
`include "gcm_defs.svh"

package gcm_pkg;

    // one 128 bit block.
    typedef logic [`GCM_BLOCK_W-1:0] block_t;

    // kind of block on the input handshake.
    typedef enum logic [1:0]
    {
        KIND_AAD  = 2'd0,   // additional authenticated data.
        KIND_TEXT = 2'd1,   // ciphertext.
        KIND_LEN  = 2'd2    // len(A) || len(C), closes the session.
    } blk_kind_e;

    // four phase handshake controller.
    typedef enum logic [1:0]
    {
        ST_IDLE   = 2'd0,   // waiting for req.
        ST_LAUNCH = 2'd1,   // start pulse to accumulator.
        ST_WAIT   = 2'd2,   // fold in progress.
        ST_ACK    = 2'd3    // ack high until req drops.
    } ctrl_state_e;

endpackage

// ==== logic/ghash_if.sv ====
// controller to GHASH accumulator.
interface ghash_if;

    logic            start;   // one cycle, launch a fold.
    logic            clear;   // with start, first block of a session.
    logic            last;    // with start, length block.
    gcm_pkg::block_t block;   // block to fold.
    logic            done;    // one cycle, S updated.

    // controller side.
    modport ctrl
    (
        output start,
        output clear,
        output last,
        output block,
        input  done
    );

    // accumulator side.
    modport dp
    (
        input  start,
        input  clear,
        input  last,
        input  block,
        output done
    );

endinterface

// ==== logic/gcm_ctrl.sv ====
`include "gcm_defs.svh"

module gcm_ctrl
(
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_req,
    input  gcm_pkg::blk_kind_e i_kind,
    input  gcm_pkg::block_t    i_block,
    output logic               o_ack,
    output logic               o_tag_valid,
    output logic               o_len_err,
    ghash_if.ctrl              gh
);

    gcm_pkg::ctrl_state_e  state;
    gcm_pkg::ctrl_state_e  state_n;

    logic                  session_open;
    logic                  is_len;
    logic                  order_err;
    logic [`GCM_CNT_W-1:0] aad_cnt;
    logic [`GCM_CNT_W-1:0] text_cnt;
    logic [`GCM_CNT_W-1:0] aad_base;
    logic [`GCM_CNT_W-1:0] text_base;
    logic                  err_base;
    logic [63:0]           aad_bits;
    logic [63:0]           text_bits;
    logic                  len_bad;

    ////////////////////
    // handshake fsm.
    ////////////////////

    always_comb
    begin
        state_n = state;
        case (state)
            gcm_pkg::ST_IDLE:
            begin
                if (i_req)
                    state_n = gcm_pkg::ST_LAUNCH;
            end
            gcm_pkg::ST_LAUNCH: state_n = gcm_pkg::ST_WAIT;
            gcm_pkg::ST_WAIT:
            begin
                if (gh.done)
                    state_n = gcm_pkg::ST_ACK;
            end
            default:
            begin
                if (!i_req)   // producer released, drop ack.
                    state_n = gcm_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
            state <= gcm_pkg::ST_IDLE;
        else
            state <= state_n;
    end

    assign o_ack    = (state == gcm_pkg::ST_ACK);
    assign gh.start = (state == gcm_pkg::ST_LAUNCH);
    assign gh.clear = !session_open;   // no open session, start over.
    assign gh.last  = (i_kind == gcm_pkg::KIND_LEN);
    assign gh.block = i_block;          // held by producer until ack.

    ////////////////////
    // session tracking.
    ////////////////////

    // a new session starts from zero counts.
    assign aad_base  = session_open ? aad_cnt : '0;
    assign text_base = session_open ? text_cnt : '0;
    assign err_base  = session_open & order_err;

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            session_open <= 1'b0;
            is_len       <= 1'b0;
            order_err    <= 1'b0;
            aad_cnt      <= '0;
            text_cnt     <= '0;
        end
        else if (gh.start)
        begin
            is_len       <= (i_kind == gcm_pkg::KIND_LEN);
            session_open <= (i_kind != gcm_pkg::KIND_LEN);
            aad_cnt      <= (i_kind == gcm_pkg::KIND_AAD) ? aad_base + 1'b1 : aad_base;
            text_cnt     <= (i_kind == gcm_pkg::KIND_TEXT) ? text_base + 1'b1 : text_base;
            // aad after any ciphertext breaks the order.
            order_err    <= err_base | ((i_kind == gcm_pkg::KIND_AAD) && (text_base != '0));
        end
    end

    // expected bit lengths, count times 128.
    assign aad_bits  = {{(64-`GCM_CNT_W-7){1'b0}}, aad_cnt, 7'd0};
    assign text_bits = {{(64-`GCM_CNT_W-7){1'b0}}, text_cnt, 7'd0};
    assign len_bad   = order_err
                     | (i_block[`GCM_BLOCK_W-1 -: 64] != aad_bits)
                     | (i_block[63:0] != text_bits);

    // flags rise with ack of the length block.
    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            o_tag_valid <= 1'b0;
            o_len_err   <= 1'b0;
        end
        else if ((state == gcm_pkg::ST_IDLE) && i_req && !session_open)
        begin
            o_tag_valid <= 1'b0;   // next session accepted.
            o_len_err   <= 1'b0;
        end
        else if ((state == gcm_pkg::ST_WAIT) && gh.done && is_len)
        begin
            o_tag_valid <= 1'b1;
            o_len_err   <= len_bad;
        end
    end

endmodule

// ==== logic/gf128_mult.sv ====
`include "gcm_defs.svh"

module gf128_mult
(
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_start,
    input  gcm_pkg::block_t i_x,
    input  gcm_pkg::block_t i_y,
    output gcm_pkg::block_t o_z,
    output logic            o_done
);

    localparam int STEPS = `GCM_BLOCK_W / `GHASH_DIGIT;
    localparam int CNT_W = $clog2(STEPS + 1);

    // R = 11100001 || 0^120.
    localparam gcm_pkg::block_t R_POLY = {8'hE1, {(`GCM_BLOCK_W-8){1'b0}}};

    gcm_pkg::block_t x_r;
    gcm_pkg::block_t v_r;
    gcm_pkg::block_t z_r;
    gcm_pkg::block_t x_n;
    gcm_pkg::block_t v_n;
    gcm_pkg::block_t z_n;
    logic [CNT_W-1:0] cnt;
    logic             busy;
    logic             done_r;

    ////////////////////
    // one digit per cycle.
    ////////////////////

    always_comb
    begin
        x_n = x_r;
        v_n = v_r;
        z_n = z_r;
        for (int i = 0; i < `GHASH_DIGIT; i++)
        begin
            if (x_n[`GCM_BLOCK_W-1])   // GCM bit 0 first.
                z_n = z_n ^ v_n;
            // V * x, shift toward higher GCM bits and reduce.
            v_n = {1'b0, v_n[`GCM_BLOCK_W-1:1]} ^ (v_n[0] ? R_POLY : '0);
            x_n = {x_n[`GCM_BLOCK_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            busy   <= 1'b0;
            done_r <= 1'b0;
            cnt    <= '0;
        end
        else
        begin
            done_r <= 1'b0;
            if (i_start)
            begin
                busy <= 1'b1;
                cnt  <= CNT_W'(STEPS - 1);
            end
            else if (busy)
            begin
                if (cnt == '0)
                begin
                    busy   <= 1'b0;
                    done_r <= 1'b1;   // product in z_r.
                end
                else
                    cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_start)
        begin
            x_r <= i_x;
            v_r <= i_y;
            z_r <= '0;
        end
        else if (busy)
        begin
            x_r <= x_n;
            v_r <= v_n;
            z_r <= z_n;
        end
    end

    assign o_z    = z_r;
    assign o_done = done_r;

endmodule

// ==== logic/ghash_accum.sv ====
module ghash_accum
(
    input  logic            clk,
    input  logic            i_rst,
    ghash_if.dp             gh,
    input  gcm_pkg::block_t i_h,
    input  gcm_pkg::block_t i_ej0,
    output gcm_pkg::block_t o_x,
    output gcm_pkg::block_t o_hmul,
    output logic            o_mult_start,
    input  gcm_pkg::block_t i_product,
    input  logic            i_mult_done,
    output gcm_pkg::block_t o_tag
);

    gcm_pkg::block_t s_r;     // running GHASH state.
    gcm_pkg::block_t h_r;
    gcm_pkg::block_t ej0_r;
    gcm_pkg::block_t x_r;     // S ^ block.
    gcm_pkg::block_t tag_r;
    logic            last_r;
    logic            start_r;
    logic            done_r;

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            start_r <= 1'b0;
            done_r  <= 1'b0;
            last_r  <= 1'b0;
        end
        else
        begin
            start_r <= gh.start;      // launch multiplier next cycle.
            done_r  <= i_mult_done;
            if (gh.start)
                last_r <= gh.last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (gh.start)
        begin
            x_r <= (gh.clear ? '0 : s_r) ^ gh.block;   // zero S on a new session.
            if (gh.clear)
            begin
                h_r   <= i_h;
                ej0_r <= i_ej0;
            end
        end
        if (i_mult_done)
        begin
            s_r <= i_product;
            if (last_r)
                tag_r <= i_product ^ ej0_r;   // tag = S ^ E(K, J0).
        end
    end

    assign o_x          = x_r;
    assign o_hmul       = h_r;
    assign o_mult_start = start_r;
    assign o_tag        = tag_r;
    assign gh.done      = done_r;

endmodule

// ==== logic/gcm_tag_top.sv ====
`include "gcm_defs.svh"

module gcm_tag_top
(
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_req,
    input  logic [1:0]              i_kind,
    input  logic [`GCM_BLOCK_W-1:0] i_block,
    input  logic [`GCM_BLOCK_W-1:0] i_h,
    input  logic [`GCM_BLOCK_W-1:0] i_ej0,
    output logic                    o_ack,
    output logic [`GCM_BLOCK_W-1:0] o_tag,
    output logic                    o_tag_valid,
    output logic                    o_len_err
);

    gcm_pkg::block_t mult_x;
    gcm_pkg::block_t mult_h;
    gcm_pkg::block_t mult_z;
    logic            mult_start;
    logic            mult_done;

    ghash_if gh ();

    gcm_ctrl u_ctrl
    (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_req       (i_req),
        .i_kind      (gcm_pkg::blk_kind_e'(i_kind)),
        .i_block     (i_block),
        .o_ack       (o_ack),
        .o_tag_valid (o_tag_valid),
        .o_len_err   (o_len_err),
        .gh          (gh.ctrl)
    );

    ghash_accum u_accum
    (
        .clk          (clk),
        .i_rst        (i_rst),
        .gh           (gh.dp),
        .i_h          (i_h),
        .i_ej0        (i_ej0),
        .o_x          (mult_x),
        .o_hmul       (mult_h),
        .o_mult_start (mult_start),
        .i_product    (mult_z),
        .i_mult_done  (mult_done),
        .o_tag        (o_tag)
    );

    gf128_mult u_mult
    (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_start (mult_start),
        .i_x     (mult_x),
        .i_y     (mult_h),
        .o_z     (mult_z),
        .o_done  (mult_done)
    );

endmodule

// ==== verif/gcm_tag_tb.sv ====
`include "gcm_defs.svh"

module gcm_tag_tb;

    localparam int TIMEOUT = 400;   // cycles allowed per wait.

    logic                    clk;
    logic                    i_rst;
    logic                    i_req;
    logic [1:0]              i_kind;
    logic [`GCM_BLOCK_W-1:0] i_block;
    logic [`GCM_BLOCK_W-1:0] i_h;
    logic [`GCM_BLOCK_W-1:0] i_ej0;
    logic                    o_ack;
    logic [`GCM_BLOCK_W-1:0] o_tag;
    logic                    o_tag_valid;
    logic                    o_len_err;

    integer          seed = 69610;
    int              n_mismatch = 0;
    int              n_proto = 0;
    int              n_timeout = 0;
    int              n_aad;
    int              n_text;
    gcm_pkg::block_t s_model;   // reference GHASH state.
    gcm_pkg::block_t h_cur;
    gcm_pkg::block_t ej0_cur;

    gcm_tag_top uut
    (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_req       (i_req),
        .i_kind      (i_kind),
        .i_block     (i_block),
        .i_h         (i_h),
        .i_ej0       (i_ej0),
        .o_ack       (o_ack),
        .o_tag       (o_tag),
        .o_tag_valid (o_tag_valid),
        .o_len_err   (o_len_err)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // handshake rules.
    ////////////////////

    // req as seen on the edge that raised ack.
    assert property (@(posedge clk) disable iff (i_rst) $rose(o_ack) |-> $past(i_req))
    else
    begin
        $display("ack rose while req was low");
        n_proto++;
    end

    assert property (@(posedge clk) disable iff (i_rst) (o_ack && i_req) |=> o_ack)
    else
    begin
        $display("ack dropped while req was still high");
        n_proto++;
    end

    assert property (@(posedge clk) disable iff (i_rst) $fell(o_ack) |-> !$past(i_req))
    else
    begin
        $display("ack fell before req was low");
        n_proto++;
    end

    // flags come up together with ack.
    assert property (@(posedge clk) disable iff (i_rst) $rose(o_tag_valid) |-> $rose(o_ack))
    else
    begin
        $display("tag_valid rose without the ack of a length block");
        n_proto++;
    end

    ////////////////////
    // reference model.
    ////////////////////

    // bitwise multiply with x[127 - i] as GCM bit i.
    function automatic gcm_pkg::block_t gf_mul(input gcm_pkg::block_t x,
                                               input gcm_pkg::block_t y);
        gcm_pkg::block_t z;
        gcm_pkg::block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < 128; i++)
        begin
            if (x[127 - i])
                z = z ^ v;
            if (v[0])
                v = (v >> 1) ^ {8'hE1, 120'd0};
            else
                v = v >> 1;
        end
        return z;
    endfunction

    function automatic gcm_pkg::block_t rand_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // len(A) || len(C) in bits.
    function automatic gcm_pkg::block_t len_block(input int a, input int c);
        return {(64'(a) << 7), (64'(c) << 7)};
    endfunction

    task automatic check_val(input string name, input gcm_pkg::block_t exp,
                             input gcm_pkg::block_t act);
        assert (act === exp)
        else
        begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            n_mismatch++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp)
        else
        begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            n_mismatch++;
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////
    // block transfer.
    ////////////////////

    task automatic start_session(input gcm_pkg::block_t h, input gcm_pkg::block_t ej0);
        h_cur   = h;
        ej0_cur = ej0;
        i_h     = h;     // stable before the first req.
        i_ej0   = ej0;
        s_model = '0;
        n_aad   = 0;
        n_text  = 0;
    endtask

    // full four phase transfer with random hold and gap.
    task automatic send(input gcm_pkg::blk_kind_e kind, input gcm_pkg::block_t blk);
        int t;
        int hold;
        hold    = $random(seed) & 3;
        i_kind  = kind;
        i_block = blk;
        i_req   = 1'b1;
        t = 0;
        while (!o_ack && t < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            t++;
        end
        if (!o_ack)
        begin
            $display("timeout, ack never rose for a %s block", kind.name());
            n_timeout++;
        end
        idle_cycles(hold);
        i_req = 1'b0;
        t = 0;
        while (o_ack && t < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            t++;
        end
        if (o_ack)
        begin
            $display("timeout, ack stayed high after req dropped");
            n_timeout++;
        end
        s_model = gf_mul(s_model ^ blk, h_cur);   // model follows the fold.
        if (kind == gcm_pkg::KIND_AAD)
            n_aad++;
        else if (kind == gcm_pkg::KIND_TEXT)
            n_text++;
        idle_cycles($random(seed) & 3);
    endtask

    task automatic close_session(input string name, input gcm_pkg::block_t len,
                                 input logic exp_err);
        send(gcm_pkg::KIND_LEN, len);
        check_bit({name, " tag_valid"}, 1'b1, o_tag_valid);
        check_bit({name, " len_err"}, exp_err, o_len_err);
        check_val({name, " tag"}, s_model ^ ej0_cur, o_tag);
    endtask

    // random keys with aad before text and correct lengths.
    task automatic run_session(input string name, input int a, input int c);
        start_session(rand_block(), rand_block());
        for (int i = 0; i < a + c; i++)
        begin
            if (i < a)
                send(gcm_pkg::KIND_AAD, rand_block());
            else
                send(gcm_pkg::KIND_TEXT, rand_block());
            if (i == 0)
                check_bit({name, " valid drop"}, 1'b0, o_tag_valid);
        end
        close_session(name, len_block(n_aad, n_text), 1'b0);
    endtask

    initial
    begin
        i_rst   = 1'b1;
        i_req   = 1'b0;
        i_kind  = 2'd0;
        i_block = '0;
        i_h     = '0;
        i_ej0   = '0;
        repeat (16) @(posedge clk);
        #1;
        i_rst = 1'b0;
        check_bit("reset ack", 1'b0, o_ack);
        check_bit("reset tag_valid", 1'b0, o_tag_valid);
        check_bit("reset len_err", 1'b0, o_len_err);
        check_bit("reset state", 1'b1, uut.u_ctrl.state == gcm_pkg::ST_IDLE);

        // zero key and iv with one zero plaintext block.
        start_session(128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
                      128'h58e2fccefa7e3061367f1d57a4e7455a);
        send(gcm_pkg::KIND_TEXT, 128'h0388dace60b6a392f328c2b971b2fe78);
        send(gcm_pkg::KIND_LEN, len_block(0, 1));
        check_val("known vector", 128'hab6e47d42cec13bdf53a67b21257bddf, o_tag);
        check_bit("known vector len_err", 1'b0, o_len_err);

        run_session("aad2 text3", 2, 3);

        // claimed lengths off by one aad block.
        start_session(rand_block(), rand_block());
        send(gcm_pkg::KIND_AAD, rand_block());
        send(gcm_pkg::KIND_TEXT, rand_block());
        close_session("bad length", len_block(n_aad + 1, n_text), 1'b1);

        // ciphertext before aad.
        start_session(rand_block(), rand_block());
        send(gcm_pkg::KIND_TEXT, rand_block());
        send(gcm_pkg::KIND_AAD, rand_block());
        close_session("order", len_block(n_aad, n_text), 1'b1);

        for (int k = 0; k < 4; k++)
            run_session("back to back", $random(seed) & 3, 1 + ($random(seed) & 3));

        $display("errors: %0d mismatch, %0d protocol, %0d timeout",
                 n_mismatch, n_proto, n_timeout);
        if (n_mismatch + n_proto + n_timeout == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/gcm_pkg.sv
logic/ghash_if.sv
logic/gcm_ctrl.sv
logic/gf128_mult.sv
logic/ghash_accum.sv
logic/gcm_tag_top.sv
verif/gcm_tag_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the GCM tag testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module gcm_tag_tb -o gcm_tag_sim

./obj_dir/gcm_tag_sim > sim.log || true
cat sim.log

if grep -q "^>>> PASS$" sim.log; then
    exit 0
else
    exit 1
fi
